// ==== bench/vita_tx_testdata.txt ====
# T numchan0 numchan1 sink_hold_cycles | W port eof word | X port (clear) | D end of test
# E port flags(send_at sob eob eop) send_time s0 s1 s2 s3
T 3 3 0
W 0 0 1E50000C
W 0 0 0000AAAA
W 0 0 C1C1C1C1
W 0 0 C2C2C2C2
W 0 0 00000012
W 0 0 00000000
W 0 0 00003456
W 0 0 11110001
W 0 0 11110002
W 0 0 11110003
W 0 0 11110004
W 0 0 7AAA0000
W 0 0 01000007
W 0 0 22220001
W 0 0 22220002
W 0 0 22220003
W 0 0 22220004
W 0 0 22220005
W 0 0 22220006
E 0 D 0000001200003456 11110001 11110002 11110003 11110004
E 0 2 0000000000000000 22220001 22220002 22220003 22220004
E 0 3 0000000000000000 22220005 22220006 00000000 00000000
W 1 0 13000007
W 1 0 0000BBBB
W 1 0 33330001
W 1 0 33330002
W 1 0 33330003
W 1 0 33330004
W 1 0 33330005
E 1 6 0000000000000000 33330001 33330002 33330003 33330004
E 1 7 0000000000000000 33330005 00000000 00000000 00000000
D
T 0 1 30
W 0 0 02800005
W 0 0 00000099
W 0 0 44440001
W 0 0 44440002
W 0 0 44440003
E 0 C 0000009900000000 44440001 00000000 00000000 00000000
E 0 C 0000009900000000 44440002 00000000 00000000 00000000
E 0 D 0000009900000000 44440003 00000000 00000000 00000000
W 1 0 08000010
W 1 0 00C00001
W 1 0 00C00002
W 1 0 55550001
W 1 0 55550002
W 1 1 55550003
W 1 0 00000003
W 1 0 66660001
W 1 0 66660002
E 1 0 0000000000000000 55550001 55550002 00000000 00000000
E 1 1 0000000000000000 55550003 00000000 00000000 00000000
E 1 1 0000000000000000 66660001 66660002 00000000 00000000
D
T 3 3 0
W 0 0 00000008
W 0 0 77770001
W 0 0 77770002
X 0
W 0 0 02000003
W 0 0 88880001
W 0 0 88880002
E 0 5 0000000000000000 88880001 88880002 00000000 00000000
W 1 0 00000005
W 1 0 99990001
W 1 0 99990002
W 1 0 99990003
W 1 0 99990004
E 1 1 0000000000000000 99990001 99990002 99990003 99990004
D

// ==== compile.f ====
src/vita_pkg.sv
src/vita_settings.sv
src/sample_queue.sv
src/vita_tx_deframer.sv
src/sample_arbiter.sv
src/vita_tx_top.sv
bench/vita_tx_props.sv
bench/vita_tx_tb.sv

// ==== Bender.yml ====
package:
  name: vita_tx

sources:
  - src/vita_pkg.sv
  - src/vita_settings.sv
  - src/sample_queue.sv
  - src/vita_tx_deframer.sv
  - src/sample_arbiter.sv
  - src/vita_tx_top.sv
  - target: test
    files:
      - bench/vita_tx_props.sv
      - bench/vita_tx_tb.sv

// ==== bench/vita_tx_tb.sv ====
`timescale 1ns/1ps

module vita_tx_tb;

   localparam int max_chan = 4;
   localparam int base = 0;
   localparam int in_depth = 4;
   localparam int out_credits = 2;
   localparam int queue_depth = 4;
   localparam int line_w = vita_pkg::line_width(max_chan);

   logic                  clk;
   logic                  rst_n_i;
   logic                  set_stb_i;
   logic [7:0]            set_addr_i;
   logic [31:0]           set_data_i;
   logic [1:0]            in_valid_i;
   logic [1:0][31:0]      in_data_i;
   logic [1:0]            in_eof_i;
   logic [1:0]            in_credit_o;
   logic                  sample_credit_i;
   logic                  sample_valid_o;
   logic [line_w-1:0]     sample_line_o;
   logic                  sample_port_o;

   int seed = 32'hf25fde69;
   int host_cred [2];
   int got [2];
   int nc [2];
   int outstanding;   // lines at the sink not yet credited
   int sink_hold;
   int hold;
   int errors;
   int checks;
   int test_num;
   int limit_cycles;
   int fd;
   logic [33:0]       items [2][$];   // {clear, eof, word} or {clear, line mark}
   logic [line_w-1:0] exp_q [2][$];

   vita_tx_top #(
      .max_chan    (max_chan),
      .base        (base),
      .in_depth    (in_depth),
      .out_credits (out_credits),
      .queue_depth (queue_depth)
   ) DUT (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .set_stb_i       (set_stb_i),
      .set_addr_i      (set_addr_i),
      .set_data_i      (set_data_i),
      .in_valid_i      (in_valid_i),
      .in_data_i       (in_data_i),
      .in_eof_i        (in_eof_i),
      .in_credit_o     (in_credit_o),
      .sample_credit_i (sample_credit_i),
      .sample_valid_o  (sample_valid_o),
      .sample_line_o   (sample_line_o),
      .sample_port_o   (sample_port_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic int count_words();
      int f;
      int n;
      int r;
      string s;
      n = 0;
      f = $fopen("bench/vita_tx_testdata.txt", "r");
      if (f == 0)
         return 0;
      while (!$feof(f))
      begin
         r = $fgets(s, f);
         if (r > 0 && s.getc(0) == "W")
            n++;
      end
      $fclose(f);
      return n;
   endfunction

   task automatic load_test(output bit found);
      string s;
      int p;
      int e;
      int r;
      logic [31:0] w;
      logic [3:0] fl;
      logic [63:0] t;
      logic [31:0] s0, s1, s2, s3;
      found = 1'b0;
      while (!$feof(fd))
      begin
         r = $fgets(s, fd);
         if (r > 0)
         begin
            case (s.getc(0))
               "T":
               begin
                  r = $sscanf(s, "T %d %d %d", nc[0], nc[1], hold);
                  found = 1'b1;
               end
               "W":
               begin
                  r = $sscanf(s, "W %d %d %h", p, e, w);
                  items[p].push_back({1'b0, e[0], w});
               end
               "X":
               begin
                  r = $sscanf(s, "X %d", p);
                  items[p].push_back({2'b10, 32'(exp_q[p].size())});
               end
               "E":
               begin
                  r = $sscanf(s, "E %d %h %h %h %h %h %h", p, fl, t, s0, s1, s2, s3);
                  exp_q[p].push_back({s3, s2, s1, s0, fl, t});
               end
               "D":
                  return;
               default:
                  ;
            endcase
         end
      end
   endtask

   task automatic write_setting(input logic [7:0] a, input logic [31:0] d);
      @(posedge clk);
      #1;
      set_stb_i = 1'b1;
      set_addr_i = a;
      set_data_i = d;
      @(posedge clk);
      #1;
      set_stb_i = 1'b0;
   endtask

   // sends while holding credits, a clear waits for an empty buffer
   task automatic run_host(input int p);
      logic [33:0] it;
      while (items[p].size() > 0)
      begin
         @(posedge clk);
         #1;
         in_valid_i[p] = 1'b0;
         it = items[p][0];
         if (it[33])
         begin
            if (host_cred[p] == in_depth && got[p] == int'(it[31:0]))
            begin
               void'(items[p].pop_front());
               write_setting(8'(base + 2 * p + 1), 32'd0);
            end
         end
         else if (host_cred[p] > 0)
         begin
            in_valid_i[p] = 1'b1;
            in_data_i[p] = it[31:0];
            in_eof_i[p] = it[32];
            host_cred[p]--;
            void'(items[p].pop_front());
         end
      end
      @(posedge clk);
      #1;
      in_valid_i[p] = 1'b0;
   endtask

   always @(posedge clk)
   begin
      if (rst_n_i)
      begin
         for (int p = 0; p < 2; p++)
         begin
            if (in_credit_o[p])
            begin
               if (host_cred[p] >= in_depth)
               begin
                  errors++;
                  $display("port %0d returned more credits than words sent", p);
               end
               else
                  host_cred[p]++;
            end
         end
      end
   end

   always @(posedge clk)
   begin
      int p;
      if (rst_n_i && sample_valid_o)
      begin
         p = sample_port_o;
         if (outstanding >= out_credits)
         begin
            errors++;
            $display("line sent at %0t with no sink credit left", $time);
         end
         outstanding++;
         if (exp_q[p].size() == 0)
         begin
            errors++;
            $display("unexpected line on port %0d at %0t", p, $time);
         end
         else
         begin
            checks++;
            if (sample_line_o !== exp_q[p][0])
            begin
               errors++;
               $display("** Error at %0t: port %0d line %0d got %h expected %h",
                        $time, p, got[p], sample_line_o, exp_q[p][0]);
            end
            void'(exp_q[p].pop_front());
            got[p]++;
         end
      end
   end

   // sink frees lines at random times
   initial
   begin
      sample_credit_i = 1'b0;
      forever
      begin
         @(posedge clk);
         #1;
         sample_credit_i = 1'b0;
         if (sink_hold > 0)
            sink_hold--;
         else if (outstanding > 0 && ($random(seed) & 3) != 0)
         begin
            sample_credit_i = 1'b1;
            outstanding--;
         end
      end
   end

   initial
   begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", limit_cycles);
      $display("=== FAIL ===");
      $finish;
   end

   task automatic run_all();
      bit found;
      int e0;
      repeat (3) @(posedge clk);
      #1 rst_n_i = 1'b1;
      test_num = 0;
      forever
      begin
         load_test(found);
         if (!found)
            break;
         test_num++;
         e0 = errors;
         got[0] = 0;
         got[1] = 0;
         write_setting(8'(base), 32'(nc[0]));
         write_setting(8'(base + 2), 32'(nc[1]));
         sink_hold = hold;
         fork
            run_host(0);
            run_host(1);
         join
         while (exp_q[0].size() + exp_q[1].size() > 0 || outstanding > 0 ||
                host_cred[0] != in_depth || host_cred[1] != in_depth)
            @(posedge clk);
         $display("test %0d done: port0 %0d lines, port1 %0d lines, %0d errors",
                  test_num, got[0], got[1], errors - e0);
      end
   endtask

   initial
   begin
      rst_n_i = 1'b0;
      set_stb_i = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      in_valid_i = '0;
      in_data_i = '0;
      in_eof_i = '0;
      host_cred[0] = in_depth;
      host_cred[1] = in_depth;
      outstanding = 0;
      sink_hold = 0;
      errors = 0;
      checks = 0;
      limit_cycles = 20 * count_words() + 200;
      fd = $fopen("bench/vita_tx_testdata.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open the test data file");
         $display("=== FAIL ===");
      end
      else
      begin
         run_all();
         $fclose(fd);
         errors = errors + DUT.u_arbiter.u_props.fail_cnt
                  + DUT.g_stream[0].u_deframer.u_props.fail_cnt
                  + DUT.g_stream[1].u_deframer.u_props.fail_cnt;
         $display("tests %0d, lines checked %0d, errors %0d", test_num, checks, errors);
         if (errors == 0)
            $display("=== PASS ===");
         else
            $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== bench/vita_tx_props.sv ====
`timescale 1ns/1ps

module vita_tx_props #(
   parameter int cnt_max = 4,
   parameter bit strobe_checks = 1'b1
) (
   input logic       clk,
   input logic       rst_n_i,
   input logic [7:0] cnt_i,     // credit or fill count of the host module
   input logic       valid_i,   // output strobe paid for by that count
   input logic [1:0] pop_i
);

   int fail_cnt = 0;

   a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n_i)
      cnt_i <= 8'(cnt_max))
      else
      begin
         fail_cnt++;
         $error("count %0d above limit %0d", cnt_i, cnt_max);
      end

   if (strobe_checks)
   begin : g_strobe
      // a strobe only rises when the count was nonzero one cycle earlier
      a_valid_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
         $rose(valid_i) |-> $past(cnt_i) != 8'd0)
         else
         begin
            fail_cnt++;
            $error("strobe raised with zero count");
         end

      a_one_pop: assert property (@(posedge clk) disable iff (!rst_n_i)
         $onehot0(pop_i))
         else
         begin
            fail_cnt++;
            $error("more than one queue pop in a cycle");
         end
   end

endmodule

bind sample_arbiter vita_tx_props #(.cnt_max(out_credits)) u_props (
   .clk     (clk),
   .rst_n_i (rst_n_i),
   .cnt_i   (8'(credits)),
   .valid_i (sample_valid_o),
   .pop_i   (q_pop_o)
);

bind vita_tx_deframer vita_tx_props #(.cnt_max(in_depth), .strobe_checks(1'b0)) u_props (
   .clk     (clk),
   .rst_n_i (rst_n_i),
   .cnt_i   (8'(buf_cnt)),   // host credits in flight
   .valid_i (in_credit_o),
   .pop_i   ({1'b0, q_pop_i})
);

// ==== src/vita_tx_top.sv ====
`timescale 1ns/1ps

module vita_tx_top #(
   parameter int max_chan = 4,
   parameter int base = 0,
   parameter int in_depth = 4,
   parameter int out_credits = 2,
   parameter int queue_depth = 4,
   localparam int line_w = vita_pkg::line_width(max_chan)
) (
   input  logic                                clk,
   input  logic                                rst_n_i,
   input  logic                                set_stb_i,
   input  logic [vita_pkg::addr_w-1:0]         set_addr_i,
   input  logic [vita_pkg::word_w-1:0]         set_data_i,
   input  logic [1:0]                          in_valid_i,
   input  logic [1:0][vita_pkg::word_w-1:0]    in_data_i,
   input  logic [1:0]                          in_eof_i,
   output logic [1:0]                          in_credit_o,
   input  logic                                sample_credit_i,
   output logic                                sample_valid_o,
   output logic [line_w-1:0]                   sample_line_o,
   output logic                                sample_port_o
);

   logic [1:0][vita_pkg::numchan_w-1:0] numchan;
   logic [1:0]                          clear;
   logic [1:0]                          q_valid;
   logic [1:0][line_w-1:0]              q_line;
   logic [1:0]                          q_pop;

   vita_settings #(
      .base (base)
   ) u_settings (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .numchan_o  (numchan),
      .clear_o    (clear)
   );

   for (genvar n = 0; n < 2; n++)
   begin : g_stream
      vita_tx_deframer #(
         .max_chan    (max_chan),
         .in_depth    (in_depth),
         .queue_depth (queue_depth)
      ) u_deframer (
         .clk         (clk),
         .rst_n_i     (rst_n_i),
         .clear_i     (clear[n]),
         .numchan_i   (numchan[n]),
         .in_valid_i  (in_valid_i[n]),
         .in_data_i   (in_data_i[n]),
         .in_eof_i    (in_eof_i[n]),
         .in_credit_o (in_credit_o[n]),
         .q_pop_i     (q_pop[n]),
         .q_valid_o   (q_valid[n]),
         .q_line_o    (q_line[n])
      );
   end

   sample_arbiter #(
      .max_chan    (max_chan),
      .out_credits (out_credits)
   ) u_arbiter (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .q_valid_i       (q_valid),
      .q_line_i        (q_line),
      .q_pop_o         (q_pop),
      .sample_credit_i (sample_credit_i),
      .sample_valid_o  (sample_valid_o),
      .sample_line_o   (sample_line_o),
      .sample_port_o   (sample_port_o)
   );

endmodule

// ==== src/sample_arbiter.sv ====
`timescale 1ns/1ps

module sample_arbiter #(
   parameter int max_chan = 4,
   parameter int out_credits = 2,
   localparam int line_w = vita_pkg::line_width(max_chan)
) (
   input  logic                   clk,
   input  logic                   rst_n_i,
   input  logic [1:0]             q_valid_i,
   input  logic [1:0][line_w-1:0] q_line_i,
   output logic [1:0]             q_pop_o,
   input  logic                   sample_credit_i,
   output logic                   sample_valid_o,
   output logic [line_w-1:0]      sample_line_o,
   output logic                   sample_port_o
);

   localparam int cred_w = $clog2(out_credits + 1);

   logic [cred_w-1:0] credits;
   logic              last_port;    // port granted most recently
   logic              grant_port;
   logic              send;

   assign send = (credits != '0) && (q_valid_i != 2'b00);

   always_comb
   begin
      if (q_valid_i == 2'b11)
         grant_port = ~last_port;   // take turns when both wait
      else
         grant_port = q_valid_i[1];
   end

   assign q_pop_o = send ? (2'b01 << grant_port) : 2'b00;

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         credits <= cred_w'(out_credits);
         last_port <= 1'b1;   // port 0 goes first
         sample_valid_o <= 1'b0;
      end
      else
      begin
         credits <= credits - cred_w'(send) + cred_w'(sample_credit_i);
         sample_valid_o <= send;
         if (send)
            last_port <= grant_port;
      end
   end

   // line and tag follow the grant by one cycle
   always_ff @(posedge clk)
   begin
      if (send)
      begin
         sample_line_o <= q_line_i[grant_port];
         sample_port_o <= grant_port;
      end
   end

endmodule

// ==== src/vita_tx_deframer.sv ====
`timescale 1ns/1ps

module vita_tx_deframer #(
   parameter int max_chan = 4,
   parameter int in_depth = 4,
   parameter int queue_depth = 4,
   localparam int line_w = vita_pkg::line_width(max_chan)
) (
   input  logic                             clk,
   input  logic                             rst_n_i,
   input  logic                             clear_i,
   input  logic [vita_pkg::numchan_w-1:0]   numchan_i,
   input  logic                             in_valid_i,
   input  logic [vita_pkg::word_w-1:0]      in_data_i,
   input  logic                             in_eof_i,
   output logic                             in_credit_o,
   input  logic                             q_pop_i,
   output logic                             q_valid_o,
   output logic [line_w-1:0]                q_line_o
);

   localparam int ptr_w = (in_depth > 1) ? $clog2(in_depth) : 1;
   localparam int cnt_w = $clog2(in_depth + 1);

   vita_pkg::deframe_state_e state;

   logic [vita_pkg::word_w:0]               buf_mem [in_depth];   // eof on top
   logic [ptr_w-1:0]                        wr_ptr;
   logic [ptr_w-1:0]                        rd_ptr;
   logic [cnt_w-1:0]                        buf_cnt;
   logic [cnt_w-1:0]                        drop_cnt;
   logic                                    head_valid;
   logic                                    head_eof;
   logic [vita_pkg::word_w-1:0]             head_data;
   logic                                    dropping;
   logic                                    pop;
   logic                                    consume;

   logic has_streamid, has_classid, has_secs, has_tics, has_trailer;
   logic classid_r, secs_r, tics_r, trailer_r, sob_r, eob_r;
   logic eop_r, eof_r;
   logic last_word;
   logic [vita_pkg::len_w-1:0]              rem;          // words left after header
   logic [vita_pkg::numchan_w-1:0]          phase;
   logic [vita_pkg::time_w-1:0]             send_time;
   logic [max_chan-1:0][vita_pkg::word_w-1:0] samples;
   logic                                    queue_space;
   logic                                    push;
   logic [line_w-1:0]                       line_in;

   function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
      if (p == ptr_w'(in_depth - 1))
         return '0;
      return p + 1'b1;
   endfunction

   // first optional word still to come, else payload
   function automatic vita_pkg::deframe_state_e prefix_next(
      input logic sid,
      input logic cid,
      input logic secs,
      input logic tics
   );
      if (sid)
         return vita_pkg::vita_streamid;
      if (cid)
         return vita_pkg::vita_classid;
      if (secs)
         return vita_pkg::vita_secs;
      if (tics)
         return vita_pkg::vita_tics;
      return vita_pkg::vita_payload;
   endfunction

   assign head_valid = (buf_cnt != '0);
   assign {head_eof, head_data} = buf_mem[rd_ptr];
   assign dropping = (drop_cnt != '0);
   // stalls only in store, flushes stale words after a clear
   assign pop = head_valid && !clear_i && (dropping || state != vita_pkg::vita_store);
   assign consume = pop && !dropping;

   assign has_streamid = (head_data[vita_pkg::hdr_type_lsb +: 4] == vita_pkg::pkt_type_sid);
   assign has_classid = head_data[vita_pkg::hdr_classid_bit];
   assign has_trailer = head_data[vita_pkg::hdr_trailer_bit];
   assign has_secs = (head_data[vita_pkg::hdr_tsi_lsb +: 2] != 2'b00);
   assign has_tics = (head_data[vita_pkg::hdr_tsf_lsb +: 2] != 2'b00);

   assign last_word = head_eof || (int'(rem) == 1 + int'(trailer_r));

   always_ff @(posedge clk)
   begin
      if (in_valid_i)
         buf_mem[wr_ptr] <= {in_eof_i, in_data_i};
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         buf_cnt <= '0;
         drop_cnt <= '0;
         in_credit_o <= 1'b0;
      end
      else
      begin
         if (in_valid_i)
            wr_ptr <= ptr_inc(wr_ptr);
         if (pop)
            rd_ptr <= ptr_inc(rd_ptr);
         buf_cnt <= buf_cnt + cnt_w'(in_valid_i) - cnt_w'(pop);
         in_credit_o <= pop;   // one credit per word taken
         if (clear_i)
            drop_cnt <= buf_cnt;
         else if (dropping && pop)
            drop_cnt <= drop_cnt - 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state <= vita_pkg::vita_header;
         {classid_r, secs_r, tics_r, trailer_r, sob_r, eob_r} <= '0;
         {eop_r, eof_r} <= '0;
         rem <= '0;
         phase <= '0;
      end
      else if (clear_i)
      begin
         state <= vita_pkg::vita_header;
         {classid_r, secs_r, tics_r, trailer_r, sob_r, eob_r} <= '0;
         {eop_r, eof_r} <= '0;
         rem <= '0;
         phase <= '0;
      end
      else if (state == vita_pkg::vita_store)
      begin
         if (queue_space)
         begin
            phase <= '0;
            if (!eop_r)
               state <= vita_pkg::vita_payload;
            else if (trailer_r && !eof_r)
               state <= vita_pkg::vita_trailer;
            else
               state <= vita_pkg::vita_header;
         end
      end
      else if (consume)
      begin
         rem <= rem - 1'b1;
         case (state)
            vita_pkg::vita_header:
            begin
               {classid_r, secs_r, tics_r, trailer_r} <=
                  {has_classid, has_secs, has_tics, has_trailer};
               sob_r <= head_data[vita_pkg::hdr_sob_bit];
               eob_r <= head_data[vita_pkg::hdr_eob_bit];
               rem <= head_data[vita_pkg::len_w-1:0] - 1'b1;
               phase <= '0;
               state <= prefix_next(has_streamid, has_classid, has_secs, has_tics);
            end
            vita_pkg::vita_streamid:
               state <= prefix_next(1'b0, classid_r, secs_r, tics_r);
            vita_pkg::vita_classid:
               state <= vita_pkg::vita_classid2;
            vita_pkg::vita_classid2:
               state <= prefix_next(1'b0, 1'b0, secs_r, tics_r);
            vita_pkg::vita_secs:
               state <= prefix_next(1'b0, 1'b0, 1'b0, tics_r);
            vita_pkg::vita_tics:
               state <= vita_pkg::vita_tics2;
            vita_pkg::vita_tics2:
               state <= vita_pkg::vita_payload;
            vita_pkg::vita_payload:
            begin
               eop_r <= last_word;
               eof_r <= head_eof;
               if (last_word || phase == numchan_i || int'(phase) == max_chan - 1)
                  state <= vita_pkg::vita_store;   // short line at packet end
               else
                  phase <= phase + 1'b1;
            end
            vita_pkg::vita_trailer:
               state <= vita_pkg::vita_header;
            default:
               state <= vita_pkg::vita_header;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (consume)
      begin
         case (state)
            vita_pkg::vita_header:
            begin
               send_time <= '0;
               samples <= '0;
            end
            vita_pkg::vita_secs:
               send_time[vita_pkg::time_w-1:vita_pkg::word_w] <= head_data;
            vita_pkg::vita_tics2:
               send_time[vita_pkg::word_w-1:0] <= head_data;   // low tics word
            vita_pkg::vita_payload:
               samples[phase] <= head_data;
            default:
               ;
         endcase
      end
      else if (push)
         samples <= '0;   // unused slots read zero
   end

   assign push = (state == vita_pkg::vita_store) && queue_space;
   assign line_in = {samples, secs_r, sob_r, eob_r, eop_r, send_time};

   sample_queue #(
      .line_w      (line_w),
      .queue_depth (queue_depth)
   ) u_queue (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .clear_i (clear_i),
      .push_i  (push),
      .line_i  (line_in),
      .space_o (queue_space),
      .valid_o (q_valid_o),
      .line_o  (q_line_o),
      .pop_i   (q_pop_i)
   );

endmodule

// ==== src/sample_queue.sv ====
`timescale 1ns/1ps

module sample_queue #(
   parameter int line_w = 132,
   parameter int queue_depth = 4
) (
   input  logic              clk,
   input  logic              rst_n_i,
   input  logic              clear_i,
   input  logic              push_i,
   input  logic [line_w-1:0] line_i,
   output logic              space_o,
   output logic              valid_o,
   output logic [line_w-1:0] line_o,
   input  logic              pop_i
);

   localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
   localparam int cnt_w = $clog2(queue_depth + 1);

   logic [line_w-1:0] mem [queue_depth];
   logic [ptr_w-1:0]  wr_ptr;
   logic [ptr_w-1:0]  rd_ptr;
   logic [cnt_w-1:0]  fill;
   logic              do_push;
   logic              do_pop;

   function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
      if (p == ptr_w'(queue_depth - 1))
         return '0;
      return p + 1'b1;
   endfunction

   assign space_o = (fill != cnt_w'(queue_depth));
   assign valid_o = (fill != '0);
   assign line_o = mem[rd_ptr];   // head, shown while valid
   assign do_push = push_i && space_o;
   assign do_pop = pop_i && valid_o;

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= line_i;
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill <= '0;
      end
      else if (clear_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= ptr_inc(wr_ptr);
         if (do_pop)
            rd_ptr <= ptr_inc(rd_ptr);
         fill <= fill + cnt_w'(do_push) - cnt_w'(do_pop);
      end
   end

endmodule

// ==== src/vita_settings.sv ====
`timescale 1ns/1ps

module vita_settings #(
   parameter int base = 0
) (
   input  logic                                   clk,
   input  logic                                   rst_n_i,
   input  logic                                   set_stb_i,
   input  logic [vita_pkg::addr_w-1:0]            set_addr_i,
   input  logic [vita_pkg::word_w-1:0]            set_data_i,
   output logic [1:0][vita_pkg::numchan_w-1:0]    numchan_o,
   output logic [1:0]                             clear_o
);

   // two registers per stream
   function automatic logic [vita_pkg::addr_w-1:0] reg_addr(
      input int                          stream,
      input logic [vita_pkg::addr_w-1:0] offset
   );
      logic [31:0] full;
      full = base + 2 * stream + offset;
      return full[vita_pkg::addr_w-1:0];
   endfunction

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         numchan_o <= '0;
         clear_o <= '0;
      end
      else
      begin
         for (int n = 0; n < 2; n++)
         begin
            clear_o[n] <= set_stb_i && (set_addr_i == reg_addr(n, vita_pkg::set_addr_clear));
            if (set_stb_i && (set_addr_i == reg_addr(n, vita_pkg::set_addr_numchan)))
               numchan_o[n] <= set_data_i[vita_pkg::numchan_w-1:0];
         end
      end
   end

endmodule

// ==== src/vita_pkg.sv ====
package vita_pkg;

   localparam int word_w = 32;
   localparam int time_w = 64;
   localparam int flag_w = 4;   // send_at, sob, eob, eop
   localparam int addr_w = 8;
   localparam int numchan_w = 2;
   localparam int len_w = 16;

   // header word fields
   localparam int hdr_type_lsb = 28;
   localparam int hdr_classid_bit = 27;
   localparam int hdr_trailer_bit = 26;
   localparam int hdr_sob_bit = 25;
   localparam int hdr_eob_bit = 24;
   localparam int hdr_tsi_lsb = 22;
   localparam int hdr_tsf_lsb = 20;
   localparam logic [3:0] pkt_type_sid = 4'd1;   // data packet with stream id

   // settings offsets, per stream
   localparam logic [addr_w-1:0] set_addr_numchan = 8'd0;
   localparam logic [addr_w-1:0] set_addr_clear = 8'd1;

   typedef enum logic [3:0] {
      vita_header,
      vita_streamid,
      vita_classid,
      vita_classid2,
      vita_secs,
      vita_tics,
      vita_tics2,
      vita_payload,
      vita_store,
      vita_trailer
   } deframe_state_e;

   // samples on top, then flags, then send time
   function automatic int line_width(input int max_chan);
      return time_w + flag_w + word_w * max_chan;
   endfunction

endpackage
